// File: design/rx_consts.svh
/* Receive chain constants */

`ifndef RX_CONSTS_SVH
`define RX_CONSTS_SVH

// Width of one real sample at the input and at the output
`define RX_SAMPLE_W 16

// Width of the NCO phase accumulator
`define RX_PHASE_W 32

// Angle width at the CORDIC, the top bits of the phase accumulator
`define RX_ANGLE_W 16

// Number of shift-add iterations in the rotator
`define RX_CORDIC_STAGES 14

// CIC filter order, integrators and combs each
`define RX_CIC_ORDER 4

// Largest decimation is 2**6 = 64
`define RX_LOG2_RATE_MAX 6

// Wishbone word addresses
`define RX_ADDR_FREQ   3'd0
`define RX_ADDR_PHASE  3'd1
`define RX_ADDR_CTRL   3'd2
`define RX_ADDR_SAMPLE 3'd3
`define RX_ADDR_STATUS 3'd4

`endif

// File: design/rx_pkg.sv
/* Receive chain types */

`include "rx_consts.svh"

package rx_pkg;

   // One complex baseband sample, I in the upper half
   typedef struct packed {
      logic signed [`RX_SAMPLE_W-1:0] i;
      logic signed [`RX_SAMPLE_W-1:0] q;
   } rx_iq_t;

   // The held output sample is filled as I/Q and read back by the host as one word
   typedef union packed {
      rx_iq_t                        iq;
      logic [2*`RX_SAMPLE_W-1:0]     raw;
   } rx_sample_u;

   // Configuration shared by every stage of the chain
   typedef struct packed {
      logic                    enable;
      logic [2:0]              log2_rate;
      logic [`RX_PHASE_W-1:0]  freq;
      logic [`RX_PHASE_W-1:0]  phase;
   } rx_cfg_t;

endpackage

// File: design/rx_wb_regs.sv
/* Wishbone register block */

`include "rx_consts.svh"

module rx_wb_regs (
   input  logic               clock_i,
   input  logic               arst_n_i,
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   input  logic               wb_we_i,
   input  logic [2:0]         wb_adr_i,
   input  logic [31:0]        wb_dat_i,
   input  logic [3:0]         wb_sel_i,
   output logic [31:0]        wb_dat_o,
   output logic               wb_ack_o,
   input  rx_pkg::rx_sample_u sample_i,
   input  logic               valid_i,
   input  logic               overrun_i,
   output rx_pkg::rx_cfg_t    cfg_o,
   output logic               sample_read_o,
   output logic               status_read_o,
   output logic               cfg_write_o
);

   logic        req;
   logic        wr;
   logic        rd;
   logic [31:0] rd_data;

   // Only byte lanes with their select bit set are replaced
   function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                               input logic [31:0] dat,
                                               input logic [3:0]  sel);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (sel[b])
            res[8*b +: 8] = dat[8*b +: 8];
      end
      return res;
   endfunction

   // Rate codes outside 1 to max snap to the nearest legal one
   function automatic logic [2:0] clamp_rate(input logic [2:0] r);
      if (r == 3'd0)
         return 3'd1;
      if (r > 3'(`RX_LOG2_RATE_MAX))
         return 3'(`RX_LOG2_RATE_MAX);
      return r;
   endfunction

   // A request counts once, in the cycle before its ack
   assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign wr  = req & wb_we_i;
   assign rd  = req & ~wb_we_i;

   // Clear and restart pulses land on the same edge as the data capture
   assign sample_read_o = rd & (wb_adr_i == `RX_ADDR_SAMPLE);
   assign status_read_o = rd & (wb_adr_i == `RX_ADDR_STATUS);
   assign cfg_write_o   = wr & (wb_adr_i == `RX_ADDR_CTRL);

   always_comb begin
      case (wb_adr_i)
         `RX_ADDR_FREQ:   rd_data = cfg_o.freq;
         `RX_ADDR_PHASE:  rd_data = cfg_o.phase;
         `RX_ADDR_CTRL:   rd_data = {28'd0, cfg_o.log2_rate, cfg_o.enable};
         `RX_ADDR_SAMPLE: rd_data = sample_i.raw;
         `RX_ADDR_STATUS: rd_data = {30'd0, overrun_i, valid_i};
         default:         rd_data = '0;
      endcase
   end

   always_ff @(posedge clock_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_ack_o <= 1'b0;
         wb_dat_o <= '0;
         // Rate code 0 is illegal, so the reset value is the smallest rate
         cfg_o    <= '{enable: 1'b0, log2_rate: 3'd1, freq: '0, phase: '0};
      end else begin
         wb_ack_o <= req;
         if (rd)
            wb_dat_o <= rd_data;
         if (wr) begin
            case (wb_adr_i)
               `RX_ADDR_FREQ:  cfg_o.freq  <= merge_bytes(cfg_o.freq, wb_dat_i, wb_sel_i);
               `RX_ADDR_PHASE: cfg_o.phase <= merge_bytes(cfg_o.phase, wb_dat_i, wb_sel_i);
               `RX_ADDR_CTRL: begin
                  // Enable and rate both live in byte lane 0
                  if (wb_sel_i[0]) begin
                     cfg_o.enable    <= wb_dat_i[0];
                     cfg_o.log2_rate <= clamp_rate(wb_dat_i[3:1]);
                  end
               end
               default: ;
            endcase
         end
      end
   end

endmodule

// File: design/rx_phase_acc.sv
/* NCO phase accumulator */

`include "rx_consts.svh"

module rx_phase_acc (
   input  logic                   clock_i,
   input  logic                   arst_n_i,
   input  rx_pkg::rx_cfg_t        cfg_i,
   input  logic                   strobe_i,
   output logic [`RX_ANGLE_W-1:0] phase_o
);

   logic [`RX_PHASE_W-1:0] acc;
   logic [`RX_PHASE_W-1:0] sum;

   // Offset is applied on the way out so it never builds up in the accumulator
   assign sum = acc + cfg_i.phase;

   always_ff @(posedge clock_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         acc     <= '0;
         phase_o <= '0;
      end else if (strobe_i && cfg_i.enable) begin
         acc     <= acc + cfg_i.freq;
         // The sample on this strobe gets the phase from before the step
         phase_o <= sum[`RX_PHASE_W-1 -: `RX_ANGLE_W];
      end
   end

endmodule

// File: design/rx_cordic.sv
/* Pipelined CORDIC mixer */

`include "rx_consts.svh"

module rx_cordic (
   input  logic                   clock_i,
   input  logic                   arst_n_i,
   input  logic                   enable_i,
   input  rx_pkg::rx_iq_t         in_i,
   input  logic                   strobe_i,
   input  logic [`RX_ANGLE_W-1:0] phase_i,
   output rx_pkg::rx_iq_t         out_o,
   output logic                   strobe_o
);

   import rx_pkg::*;

   localparam int N  = `RX_CORDIC_STAGES;
   localparam int W  = `RX_SAMPLE_W;
   // Two fraction guard bits plus two bits for the CORDIC gain and diagonal growth
   localparam int XW = W + 4;
   localparam int ZW = `RX_ANGLE_W;

   rx_iq_t               in_d;
   logic                 in_v;
   logic signed [XW-1:0] xs;
   logic signed [XW-1:0] ys;
   logic signed [XW-1:0] x_rot;
   logic signed [XW-1:0] y_rot;
   logic [1:0]           quad;
   logic signed [XW-1:0] x_q [0:N];
   logic signed [XW-1:0] y_q [0:N];
   logic signed [ZW-1:0] z_q [0:N-1];
   logic [N:0]           v_q;

   // Arctangent of 2**-k with a full turn equal to 2**16
   function automatic logic signed [ZW-1:0] atan_tab(input int k);
      case (k)
         0:       return 16'sd8192;
         1:       return 16'sd4836;
         2:       return 16'sd2555;
         3:       return 16'sd1297;
         4:       return 16'sd651;
         5:       return 16'sd326;
         6:       return 16'sd163;
         7:       return 16'sd81;
         8:       return 16'sd41;
         9:       return 16'sd20;
         10:      return 16'sd10;
         11:      return 16'sd5;
         12:      return 16'sd3;
         13:      return 16'sd1;
         default: return '0;
      endcase
   endfunction

   // About 0.6073, the inverse of the CORDIC gain
   function automatic logic signed [XW-1:0] gain_comp(input logic signed [XW-1:0] v);
      return (v >>> 1) + (v >>> 3) - (v >>> 6) - (v >>> 9) - (v >>> 13);
   endfunction

   // Drop the guard bits with rounding and clip to the sample range
   function automatic logic signed [W-1:0] round_sat(input logic signed [XW-1:0] v);
      logic signed [XW-1:0] r;
      r = (v + 2) >>> 2;
      if (r > 32767)
         return 16'sh7fff;
      if (r < -32768)
         return 16'sh8000;
      return r[W-1:0];
   endfunction

   // Sample scaled up by the guard bits
   assign xs = {{2{in_d.i[W-1]}}, in_d.i, 2'b00};
   assign ys = {{2{in_d.q[W-1]}}, in_d.q, 2'b00};

   // Nearest quarter turn, so the residual angle stays within plus or minus 45 degrees
   assign quad = phase_i[ZW-1 -: 2] + {1'b0, phase_i[ZW-3]};

   always_comb begin
      case (quad)
         2'd0: begin
            x_rot = xs;
            y_rot = ys;
         end
         2'd1: begin
            x_rot = -ys;
            y_rot = xs;
         end
         2'd2: begin
            x_rot = -xs;
            y_rot = -ys;
         end
         default: begin
            x_rot = ys;
            y_rot = -xs;
         end
      endcase
   end

   // Datapath pipeline, frozen while disabled
   always_ff @(posedge clock_i) begin
      if (enable_i) begin
         // Waits one cycle for the registered NCO phase
         if (strobe_i)
            in_d <= in_i;
         x_q[0] <= x_rot;
         y_q[0] <= y_rot;
         z_q[0] <= {{2{phase_i[ZW-3]}}, phase_i[ZW-3:0]};
         for (int k = 0; k < N; k++) begin
            // Turn toward zero residual angle
            if (z_q[k][ZW-1]) begin
               x_q[k+1] <= x_q[k] + (y_q[k] >>> k);
               y_q[k+1] <= y_q[k] - (x_q[k] >>> k);
            end else begin
               x_q[k+1] <= x_q[k] - (y_q[k] >>> k);
               y_q[k+1] <= y_q[k] + (x_q[k] >>> k);
            end
            if (k < N - 1)
               z_q[k+1] <= z_q[k][ZW-1] ? z_q[k] + atan_tab(k) : z_q[k] - atan_tab(k);
         end
      end
   end

   // Strobe travels alongside the data
   always_ff @(posedge clock_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         in_v <= 1'b0;
         v_q  <= '0;
      end else if (enable_i) begin
         in_v <= strobe_i;
         v_q  <= {v_q[N-1:0], in_v};
      end
   end

   assign out_o.i  = round_sat(gain_comp(x_q[N]));
   assign out_o.q  = round_sat(gain_comp(y_q[N]));
   assign strobe_o = v_q[N] & enable_i;

endmodule

// File: design/rx_cic_decim.sv
/* CIC decimator */

`include "rx_consts.svh"

module rx_cic_decim (
   input  logic                           clock_i,
   input  logic                           arst_n_i,
   input  logic                           enable_i,
   input  logic [2:0]                     log2_rate_i,
   input  logic                           strobe_i,
   input  logic                           decim_strobe_i,
   input  logic signed [`RX_SAMPLE_W-1:0] data_i,
   output logic signed [`RX_SAMPLE_W-1:0] data_o,
   output logic                           strobe_o
);

   localparam int N  = `RX_CIC_ORDER;
   localparam int W  = `RX_SAMPLE_W;
   // Enough bits for a gain of 2**(N*6), so wrapping integrators stay exact
   localparam int AW = W + N * `RX_LOG2_RATE_MAX;
   localparam int SW = $clog2(N * `RX_LOG2_RATE_MAX + 1);

   logic signed [AW-1:0] integ_q [0:N-1];
   logic signed [AW-1:0] integ_d [0:N-1];
   logic signed [AW-1:0] dly_q   [0:N-1];
   logic signed [AW-1:0] comb    [0:N];
   logic [SW-1:0]        shift;
   logic signed [AW-1:0] scaled;

   always_comb begin
      // Integrator chain including the sample that arrives this cycle
      integ_d[0] = integ_q[0] + AW'(data_i);
      for (int k = 1; k < N; k++)
         integ_d[k] = integ_q[k] + integ_d[k-1];
      // Combs work on the group's final integrator value
      comb[0] = integ_d[N-1];
      for (int k = 0; k < N; k++)
         comb[k+1] = comb[k] - dly_q[k];
   end

   // The gain of rate**N is a power of two, so one rounded shift removes it
   assign shift  = SW'(N * log2_rate_i);
   assign scaled = (comb[N] + (AW'(1) <<< (shift - 1))) >>> shift;

   always_ff @(posedge clock_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int k = 0; k < N; k++) begin
            integ_q[k] <= '0;
            dly_q[k]   <= '0;
         end
         strobe_o <= 1'b0;
      end else begin
         strobe_o <= decim_strobe_i & enable_i;
         if (enable_i && strobe_i) begin
            for (int k = 0; k < N; k++)
               integ_q[k] <= integ_d[k];
         end
         if (enable_i && decim_strobe_i) begin
            for (int k = 0; k < N; k++)
               dly_q[k] <= comb[k];
         end
      end
   end

   // Output word, one per decimation group
   always_ff @(posedge clock_i) begin
      if (enable_i && decim_strobe_i)
         data_o <= scaled[W-1:0];
   end

endmodule

// File: design/rx_sample_port.sv
/* Decimation strobe and sample capture */

`include "rx_consts.svh"

module rx_sample_port (
   input  logic                           clock_i,
   input  logic                           arst_n_i,
   input  rx_pkg::rx_cfg_t                cfg_i,
   input  logic                           restart_i,
   input  logic                           strobe_i,
   input  logic signed [`RX_SAMPLE_W-1:0] i_i,
   input  logic signed [`RX_SAMPLE_W-1:0] q_i,
   input  logic                           i_strobe_i,
   output logic                           decim_strobe_o,
   output rx_pkg::rx_sample_u             sample_o,
   output logic                           valid_o,
   output logic                           overrun_o,
   input  logic                           sample_read_i,
   input  logic                           status_read_i
);

   localparam int CW = `RX_LOG2_RATE_MAX;

   logic [CW-1:0] cnt_q;
   logic [CW-1:0] last;
   logic          capture;

   // Count of the last strobe in a group, rate minus one
   assign last = ~({CW{1'b1}} << cfg_i.log2_rate);

   // Fires together with the strobe that closes the group
   assign decim_strobe_o = cfg_i.enable & strobe_i & (cnt_q == last);

   // Q shares the decimation strobe, so the I strobe alone marks new data
   assign capture = cfg_i.enable & i_strobe_i;

   always_ff @(posedge clock_i or negedge arst_n_i) begin
      if (!arst_n_i)
         cnt_q <= '0;
      else if (restart_i)
         cnt_q <= '0;
      else if (cfg_i.enable && strobe_i)
         cnt_q <= (cnt_q == last) ? '0 : cnt_q + 1'b1;
   end

   always_ff @(posedge clock_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sample_o  <= '0;
         valid_o   <= 1'b0;
         overrun_o <= 1'b0;
      end else begin
         if (capture) begin
            sample_o.iq.i <= i_i;
            sample_o.iq.q <= q_i;
         end
         // A new sample wins over a clear on the same edge
         if (capture)
            valid_o <= 1'b1;
         else if (sample_read_i)
            valid_o <= 1'b0;
         // Not an overrun if the old sample is being read out on this edge
         if (capture && valid_o && !sample_read_i)
            overrun_o <= 1'b1;
         else if (status_read_i)
            overrun_o <= 1'b0;
      end
   end

endmodule

// File: design/rx_chain.sv
/* Receive chain top */

`include "rx_consts.svh"

module rx_chain (
   input  logic           clock_i,
   input  logic           arst_n_i,
   input  rx_pkg::rx_iq_t in_iq_i,
   input  logic           sample_strobe_i,
   input  logic           wb_cyc_i,
   input  logic           wb_stb_i,
   input  logic           wb_we_i,
   input  logic [2:0]     wb_adr_i,
   input  logic [31:0]    wb_dat_i,
   input  logic [3:0]     wb_sel_i,
   output logic [31:0]    wb_dat_o,
   output logic           wb_ack_o,
   output logic           irq_o
);

   import rx_pkg::*;

   rx_cfg_t                       cfg;
   logic [`RX_ANGLE_W-1:0]        phase;
   rx_iq_t                        mixed;
   logic                          mixed_strobe;
   logic                          decim_strobe;
   logic signed [`RX_SAMPLE_W-1:0] cic_i_out;
   logic signed [`RX_SAMPLE_W-1:0] cic_q_out;
   logic                          cic_i_strobe;
   rx_sample_u                    sample;
   logic                          sample_valid;
   logic                          sample_overrun;
   logic                          sample_read_clr;
   logic                          status_read_clr;
   logic                          cfg_write;

   // Interrupt is raised while an unread sample is held
   assign irq_o = sample_valid;

   rx_wb_regs regs_i (
      .clock_i       (clock_i),
      .arst_n_i      (arst_n_i),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .wb_sel_i      (wb_sel_i),
      .wb_dat_o      (wb_dat_o),
      .wb_ack_o      (wb_ack_o),
      .sample_i      (sample),
      .valid_i       (sample_valid),
      .overrun_i     (sample_overrun),
      .cfg_o         (cfg),
      .sample_read_o (sample_read_clr),
      .status_read_o (status_read_clr),
      .cfg_write_o   (cfg_write)
   );

   rx_phase_acc nco_i (
      .clock_i  (clock_i),
      .arst_n_i (arst_n_i),
      .cfg_i    (cfg),
      .strobe_i (sample_strobe_i),
      .phase_o  (phase)
   );

   rx_cordic cordic_i (
      .clock_i  (clock_i),
      .arst_n_i (arst_n_i),
      .enable_i (cfg.enable),
      .in_i     (in_iq_i),
      .strobe_i (sample_strobe_i),
      .phase_i  (phase),
      .out_o    (mixed),
      .strobe_o (mixed_strobe)
   );

   rx_cic_decim cic_i (
      .clock_i        (clock_i),
      .arst_n_i       (arst_n_i),
      .enable_i       (cfg.enable),
      .log2_rate_i    (cfg.log2_rate),
      .strobe_i       (mixed_strobe),
      .decim_strobe_i (decim_strobe),
      .data_i         (mixed.i),
      .data_o         (cic_i_out),
      .strobe_o       (cic_i_strobe)
   );

   // Its strobe is identical to the I channel's
   rx_cic_decim cic_q (
      .clock_i        (clock_i),
      .arst_n_i       (arst_n_i),
      .enable_i       (cfg.enable),
      .log2_rate_i    (cfg.log2_rate),
      .strobe_i       (mixed_strobe),
      .decim_strobe_i (decim_strobe),
      .data_i         (mixed.q),
      .data_o         (cic_q_out),
      .strobe_o       ()
   );

   rx_sample_port port_i (
      .clock_i        (clock_i),
      .arst_n_i       (arst_n_i),
      .cfg_i          (cfg),
      .restart_i      (cfg_write),
      .strobe_i       (mixed_strobe),
      .i_i            (cic_i_out),
      .q_i            (cic_q_out),
      .i_strobe_i     (cic_i_strobe),
      .decim_strobe_o (decim_strobe),
      .sample_o       (sample),
      .valid_o        (sample_valid),
      .overrun_o      (sample_overrun),
      .sample_read_i  (sample_read_clr),
      .status_read_i  (status_read_clr)
   );

endmodule

// File: verif/rx_chain_tb.sv
/* Receive chain testbench */

`include "rx_consts.svh"

module rx_chain_tb;

   import rx_pkg::*;

   localparam int WAIT_MAX = 200;
   // Rising edges from the strobe that closes a group to valid
   localparam int LATENCY  = `RX_CORDIC_STAGES + 4;
   localparam int GROUPS   = 3;

   logic        clock_i;
   logic        arst_n_i;
   rx_iq_t      in_iq_i;
   logic        sample_strobe_i;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [2:0]  wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [3:0]  wb_sel_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic        irq_o;

   int          check_errors = 0;
   int          protocol_errors = 0;
   int          timeouts = 0;
   int          rise_count;
   logic        irq_seen;
   logic [31:0] rng_state = 32'h775a;

   // Port names match the DUT one to one
   rx_chain dut_i (.*);

   initial begin
      clock_i = 1'b0;
      forever #4 clock_i = ~clock_i;
   end

   // Counts each rising edge of the interrupt, which mirrors valid
   always @(posedge clock_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         irq_seen   <= 1'b0;
         rise_count <= 0;
      end else begin
         irq_seen <= irq_o;
         if (irq_o && !irq_seen)
            rise_count <= rise_count + 1;
      end
   end

   task automatic note_protocol_error(input string what);
      protocol_errors++;
      $display("FAILED at %0t: %s", $time, what);
   endtask

   // Every ack is a single-cycle pulse
   ack_single: assert property (@(posedge clock_i) disable iff (!arst_n_i)
      wb_ack_o |=> !wb_ack_o)
      else note_protocol_error("ack stayed high for more than one cycle");

   // A fresh request is acked on the very next edge
   ack_next: assert property (@(posedge clock_i) disable iff (!arst_n_i)
      (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
      else note_protocol_error("request was not acked on the following cycle");

   // With the chain disabled a cleared sample stays cleared
   no_valid_when_off: assert property (@(posedge clock_i) disable iff (!arst_n_i)
      (!dut_i.cfg.enable && !irq_o) |=> !irq_o)
      else note_protocol_error("valid rose while the chain was disabled");

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic draw_word(output logic [31:0] w);
      rng_state = xorshift(rng_state);
      w = rng_state;
   endtask

   task automatic draw_iq(output rx_iq_t iq);
      logic [31:0] w;
      draw_word(w);
      // Kept to 14 bits so neither the rotation nor the gain can saturate
      iq.i = {{3{w[13]}}, w[12:0]};
      iq.q = {{3{w[29]}}, w[28:16]};
   endtask

   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else begin
         check_errors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // CORDIC rounding and the approximate gain allow a few LSB of error
   task automatic check_near(input string what, input int got, input int exp);
      assert (got - exp <= 4 && exp - got <= 4)
      else begin
         check_errors++;
         $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic end_run();
      $display("Errors: %0d check, %0d protocol, %0d timeout",
               check_errors, protocol_errors, timeouts);
      if (check_errors + protocol_errors + timeouts == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("Timed out at %0t while waiting for %s", $time, what);
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(negedge clock_i);
   endtask

   // One Wishbone classic access, entered and left on a falling edge
   task automatic bus_cycle(input logic we, input logic [2:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel,
                            output logic [31:0] rdata);
      int n;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      n = 0;
      while (!wb_ack_o && n < WAIT_MAX) begin
         @(negedge clock_i);
         n++;
      end
      if (!wb_ack_o)
         report_timeout("a Wishbone acknowledge");
      else
         check_equal("ack latency", 32'(n), 32'd1);
      rdata    = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      // Idle cycle so the next request is seen with ack low
      @(negedge clock_i);
   endtask

   task automatic bus_write(input logic [2:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, dat, sel, unused);
   endtask

   task automatic bus_read(input logic [2:0] adr, output logic [31:0] dat);
      bus_cycle(1'b0, adr, 32'd0, 4'hf, dat);
   endtask

   // One strobe per cycle, all with the same sample
   task automatic send_strobes(input int count, input rx_iq_t iq);
      for (int k = 0; k < count; k++) begin
         in_iq_i         = iq;
         sample_strobe_i = 1'b1;
         @(negedge clock_i);
      end
      sample_strobe_i = 1'b0;
   endtask

   // Entered one edge after the last strobe, so n counts edges from that strobe
   task automatic wait_for_valid(output int n);
      n = 1;
      while (!irq_o && n < WAIT_MAX) begin
         @(negedge clock_i);
         n++;
      end
      if (!irq_o)
         report_timeout("the sample valid flag");
   endtask

   // Eight groups at rate 8 flush the CIC history before the read
   task automatic settle_and_read(input rx_iq_t iq, output rx_sample_u s);
      logic [31:0] d;
      send_strobes(64, iq);
      idle(LATENCY + 4);
      bus_read(`RX_ADDR_SAMPLE, d);
      s.raw = d;
      // Back to back groups leave overrun set
      bus_read(`RX_ADDR_STATUS, d);
   endtask

   initial begin
      rx_iq_t      iq;
      rx_sample_u  s;
      logic [31:0] d;
      logic [31:0] w;
      logic [31:0] w2;
      int          n;
      int          base;

      in_iq_i         = '0;
      sample_strobe_i = 1'b0;
      wb_cyc_i        = 1'b0;
      wb_stb_i        = 1'b0;
      wb_we_i         = 1'b0;
      wb_adr_i        = '0;
      wb_dat_i        = '0;
      wb_sel_i        = '0;
      arst_n_i        = 1'b0;
      repeat (2) @(posedge clock_i);
      @(negedge clock_i);
      arst_n_i = 1'b1;
      @(negedge clock_i);

      // Reset values, readback and rate clamping
      check_equal("ack and irq after reset", {30'd0, wb_ack_o, irq_o}, 32'd0);
      bus_read(`RX_ADDR_FREQ, d);
      check_equal("FREQ after reset", d, 32'd0);
      bus_read(`RX_ADDR_PHASE, d);
      check_equal("PHASE after reset", d, 32'd0);
      bus_read(`RX_ADDR_CTRL, d);
      check_equal("CTRL after reset", d, 32'h2);
      bus_read(`RX_ADDR_SAMPLE, d);
      check_equal("SAMPLE after reset", d, 32'd0);
      bus_read(`RX_ADDR_STATUS, d);
      check_equal("STATUS after reset", d, 32'd0);
      draw_word(w);
      bus_write(`RX_ADDR_FREQ, w, 4'hf);
      bus_read(`RX_ADDR_FREQ, d);
      check_equal("FREQ readback", d, w);
      // Only the low byte lane is replaced
      draw_word(w2);
      bus_write(`RX_ADDR_FREQ, w2, 4'b0001);
      bus_read(`RX_ADDR_FREQ, d);
      check_equal("FREQ byte write", d, {w[31:8], w2[7:0]});
      draw_word(w);
      bus_write(`RX_ADDR_PHASE, w, 4'hf);
      bus_read(`RX_ADDR_PHASE, d);
      check_equal("PHASE readback", d, w);
      bus_write(`RX_ADDR_CTRL, 32'he, 4'hf);
      bus_read(`RX_ADDR_CTRL, d);
      check_equal("CTRL rate 7 clamped", d, 32'hc);
      bus_write(`RX_ADDR_CTRL, 32'h0, 4'hf);
      bus_read(`RX_ADDR_CTRL, d);
      check_equal("CTRL rate 0 clamped", d, 32'h2);
      bus_write(`RX_ADDR_CTRL, 32'h8, 4'hf);
      bus_read(`RX_ADDR_CTRL, d);
      check_equal("CTRL rate 4", d, 32'h8);

      // DC passes unchanged with no mixing, at rate 8
      bus_write(`RX_ADDR_FREQ, 32'd0, 4'hf);
      bus_write(`RX_ADDR_PHASE, 32'd0, 4'hf);
      bus_write(`RX_ADDR_CTRL, 32'h7, 4'hf);
      draw_iq(iq);
      settle_and_read(iq, s);
      check_near("DC I", int'(s.iq.i), int'(iq.i));
      check_near("DC Q", int'(s.iq.q), int'(iq.q));

      // Half a turn negates both components
      bus_write(`RX_ADDR_PHASE, 32'h8000_0000, 4'hf);
      draw_iq(iq);
      settle_and_read(iq, s);
      check_near("180 degree I", int'(s.iq.i), -int'(iq.i));
      check_near("180 degree Q", int'(s.iq.q), -int'(iq.q));

      // A quarter turn maps (i, q) to (-q, i)
      bus_write(`RX_ADDR_PHASE, 32'h4000_0000, 4'hf);
      draw_iq(iq);
      settle_and_read(iq, s);
      check_near("90 degree I", int'(s.iq.i), -int'(iq.q));
      check_near("90 degree Q", int'(s.iq.q), int'(iq.i));
      bus_write(`RX_ADDR_PHASE, 32'd0, 4'hf);

      // K groups give K valid rises at every rate
      for (int r = 1; r <= `RX_LOG2_RATE_MAX; r++) begin
         bus_write(`RX_ADDR_CTRL, 32'((r << 1) | 1), 4'hf);
         base = rise_count;
         for (int g = 0; g < GROUPS; g++) begin
            draw_iq(iq);
            send_strobes(1 << r, iq);
            wait_for_valid(n);
            if (g == 0)
               check_equal("first sample latency", 32'(n), 32'(LATENCY));
            bus_read(`RX_ADDR_SAMPLE, d);
         end
         idle(LATENCY);
         check_equal("valid rises", 32'(rise_count - base), 32'(GROUPS));
      end

      // Two samples without a read set overrun, and each flag clears on its own read
      bus_write(`RX_ADDR_CTRL, 32'h3, 4'hf);
      draw_iq(iq);
      send_strobes(2, iq);
      wait_for_valid(n);
      send_strobes(2, iq);
      idle(LATENCY);
      bus_read(`RX_ADDR_STATUS, d);
      check_equal("STATUS after overrun", d, 32'h3);
      bus_read(`RX_ADDR_STATUS, d);
      check_equal("STATUS after status read", d, 32'h1);
      check_equal("irq with sample held", {31'd0, irq_o}, 32'd1);
      bus_read(`RX_ADDR_SAMPLE, d);
      s.raw = d;
      check_equal("irq after sample read", {31'd0, irq_o}, 32'd0);
      bus_read(`RX_ADDR_STATUS, d);
      check_equal("STATUS after sample read", d, 32'd0);

      // Disabled chain ignores strobes and keeps the held sample
      bus_write(`RX_ADDR_CTRL, 32'h2, 4'hf);
      base = rise_count;
      draw_iq(iq);
      send_strobes(64, iq);
      idle(2 * LATENCY);
      check_equal("valid rises while disabled", 32'(rise_count - base), 32'd0);
      bus_read(`RX_ADDR_SAMPLE, d);
      check_equal("held sample while disabled", d, s.raw);
      bus_read(`RX_ADDR_STATUS, d);
      check_equal("STATUS while disabled", d, 32'd0);

      end_run();
   end

endmodule

// File: rx_chain.f
+incdir+design
design/rx_pkg.sv
design/rx_wb_regs.sv
design/rx_phase_acc.sv
design/rx_cordic.sv
design/rx_cic_decim.sv
design/rx_sample_port.sv
design/rx_chain.sv
verif/rx_chain_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the receive chain testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert \
   -f rx_chain.f \
   --top-module rx_chain_tb \
   -o rx_chain_sim \
   > build.log 2>&1 \
   && ./obj_dir/rx_chain_sim > sim.log 2>&1 \
   && grep -q "All tests passed" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
